// ==== logic/button_conditioner.sv ====
`default_nettype none

module button_conditioner
    import seg_game_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     sample,
    input  wire buttons_t btn,
    output buttons_t      press
);

    localparam int NUM_BTN = 4;

    logic [NUM_BTN-1:0] btn_bits;
    logic [NUM_BTN-1:0] level;
    logic [NUM_BTN-1:0] level_q;
    logic [NUM_BTN-1:0] press_bits;
    logic [3:0]         shift_q [NUM_BTN];

    assign btn_bits = btn;
    assign press    = buttons_t'(press_bits);

    // Down only after four high samples in a row
    always_comb begin
        for (int i = 0; i < NUM_BTN; i++) begin
            level[i] = (shift_q[i] == 4'b1111);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_BTN; i++) begin
                shift_q[i] <= '0;
            end
            level_q    <= '0;
            press_bits <= '0;
        end else begin
            for (int i = 0; i < NUM_BTN; i++) begin
                if (sample) begin
                    shift_q[i] <= {shift_q[i][2:0], btn_bits[i]};
                end
                // Rising edge of the debounced level
                press_bits[i] <= level[i] & ~level_q[i];
                level_q[i]    <= level[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/seg_game_defs.svh ====
`ifndef SEG_GAME_DEFS_SVH
`define SEG_GAME_DEFS_SVH

// Clock cycles per button sample strobe
`define SEG_SAMPLE_DIV 16

// Clock cycles per step strobe
`define SEG_STEP_DIV 256

// Clock cycles per blink phase toggle
`define SEG_BLINK_DIV 64

// Step strobes spent in INITIAL
`define SEG_START_STEPS 3

// Step strobes spent in FALLING
`define SEG_FALL_STEPS 2

`endif

// ==== logic/seg_game_pkg.sv ====
`default_nettype none

package seg_game_pkg;

    typedef enum logic [1:0] {
        INITIAL = 2'd0,
        MOVING  = 2'd1,
        FALLING = 2'd2
    } game_state_e;

    // Heading also names the buttons
    typedef enum logic [1:0] {
        RIGHT = 2'd0,
        LEFT  = 2'd1,
        UP    = 2'd2,
        DOWN  = 2'd3
    } heading_e;

    // Index into a 7-bit segment vector
    typedef enum logic [2:0] {
        SEG_A = 3'd0,
        SEG_B = 3'd1,
        SEG_C = 3'd2,
        SEG_D = 3'd3,
        SEG_E = 3'd4,
        SEG_F = 3'd5,
        SEG_G = 3'd6
    } seg_id_e;

    typedef struct packed {
        logic right;
        logic left;
        logic up;
        logic down;
    } buttons_t;

    typedef struct packed {
        logic sample;
        logic step;
        logic blink;
    } ticks_t;

    typedef struct packed {
        seg_id_e     seg;
        logic [6:0]  record;
        game_state_e state;
    } walker_view_t;

endpackage

`default_nettype wire

// ==== logic/seg_game_top.sv ====
`default_nettype none

module seg_game_top
    import seg_game_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire buttons_t btn,
    output logic [6:0]    seg_n,
    output logic [3:0]    digit_n,
    output heading_e      heading,
    output game_state_e   state
);

    ticks_t       ticks;
    logic         blink_phase;
    buttons_t     press;
    walker_view_t view;

    tick_gen u_tick_gen (
        .clk         (clk),
        .rst         (rst),
        .ticks       (ticks),
        .blink_phase (blink_phase)
    );

    button_conditioner u_button_conditioner (
        .clk    (clk),
        .rst    (rst),
        .sample (ticks.sample),
        .btn    (btn),
        .press  (press)
    );

    segment_walker u_segment_walker (
        .clk     (clk),
        .rst     (rst),
        .step    (ticks.step),
        .press   (press),
        .view    (view),
        .heading (heading)
    );

    segment_flasher u_segment_flasher (
        .clk         (clk),
        .rst         (rst),
        .view        (view),
        .blink_phase (blink_phase),
        .seg_n       (seg_n),
        .digit_n     (digit_n)
    );

    assign state = view.state;

endmodule

`default_nettype wire

// ==== logic/segment_flasher.sv ====
`default_nettype none

module segment_flasher
    import seg_game_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire walker_view_t view,
    input  wire logic         blink_phase,
    output logic [6:0]        seg_n,
    output logic [3:0]        digit_n
);

    logic [6:0] seg_pattern;
    logic [3:0] digit_pattern;

    always_comb begin
        seg_pattern = ~view.record;
        // Current segment lit only in the high blink phase
        seg_pattern[view.seg] = ~blink_phase;

        if (view.state == FALLING && !blink_phase) begin
            digit_pattern = 4'b1111;
        end else begin
            digit_pattern = 4'b1110;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seg_n   <= '1;
            digit_n <= '1;
        end else begin
            seg_n   <= seg_pattern;
            digit_n <= digit_pattern;
        end
    end

endmodule

`default_nettype wire

// ==== logic/segment_walker.sv ====
`default_nettype none

`include "seg_game_defs.svh"

module segment_walker
    import seg_game_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     step,
    input  wire buttons_t press,
    output walker_view_t  view,
    output heading_e      heading
);

    localparam int STEP_MAX = (`SEG_START_STEPS > `SEG_FALL_STEPS) ?
                              `SEG_START_STEPS : `SEG_FALL_STEPS;
    localparam int CNT_W    = $clog2(STEP_MAX + 1);

    game_state_e state_q;
    seg_id_e     seg_q;
    heading_e    heading_q;
    logic [6:0]  record_q;
    logic [CNT_W-1:0] step_cnt;

    logic        press_any;
    heading_e    press_dir;
    seg_id_e     move_seg;
    heading_e    move_heading;
    logic        start_done;
    logic        fall_done;

    assign start_done = step && (step_cnt == CNT_W'(`SEG_START_STEPS - 1));
    assign fall_done  = step && (step_cnt == CNT_W'(`SEG_FALL_STEPS - 1));

    // Lowest button wins if several pulse together
    always_comb begin
        press_any = press.right | press.left | press.up | press.down;
        press_dir = RIGHT;
        if (press.right) begin
            press_dir = RIGHT;
        end else if (press.left) begin
            press_dir = LEFT;
        end else if (press.up) begin
            press_dir = UP;
        end else if (press.down) begin
            press_dir = DOWN;
        end
    end

    // Move table
    always_comb begin
        move_seg     = seg_q;
        move_heading = heading_q;
        case (seg_q)
            SEG_A: if (heading_q == RIGHT) begin
                move_seg     = SEG_B;
                move_heading = DOWN;
            end
            SEG_B: if (heading_q == DOWN) begin
                move_seg     = SEG_G;
                move_heading = LEFT;
            end
            SEG_C: if (heading_q == DOWN) begin
                move_seg     = SEG_D;
                move_heading = LEFT;
            end
            SEG_D: if (heading_q == LEFT) begin
                move_seg     = SEG_E;
                move_heading = UP;
            end
            SEG_E: if (heading_q == UP) begin
                move_seg     = SEG_G;
                move_heading = RIGHT;
            end
            SEG_F: if (heading_q == UP) begin
                move_seg     = SEG_A;
                move_heading = RIGHT;
            end
            SEG_G: begin
                if (heading_q == RIGHT) begin
                    move_seg     = SEG_C;
                    move_heading = DOWN;
                end else if (heading_q == LEFT) begin
                    move_seg     = SEG_F;
                    move_heading = UP;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= INITIAL;
            seg_q     <= SEG_G;
            heading_q <= LEFT;
            record_q  <= '0;
            step_cnt  <= '0;
        end else begin
            case (state_q)
                INITIAL: begin
                    if (start_done) begin
                        state_q  <= MOVING;
                        step_cnt <= '0;
                    end else if (step) begin
                        step_cnt <= step_cnt + 1'b1;
                    end
                end
                MOVING: begin
                    if (press_any) begin
                        if (press_dir == heading_q) begin
                            seg_q              <= move_seg;
                            heading_q          <= move_heading;
                            record_q[move_seg] <= 1'b1;
                        end else begin
                            // Wrong way makes the walker fall
                            state_q  <= FALLING;
                            step_cnt <= '0;
                        end
                    end
                end
                FALLING: begin
                    if (fall_done) begin
                        state_q   <= INITIAL;
                        seg_q     <= SEG_G;
                        heading_q <= LEFT;
                        record_q  <= '0;
                        step_cnt  <= '0;
                    end else if (step) begin
                        step_cnt <= step_cnt + 1'b1;
                    end
                end
                default: begin
                    state_q  <= INITIAL;
                    step_cnt <= '0;
                end
            endcase
        end
    end

    assign view.seg    = seg_q;
    assign view.record = record_q;
    assign view.state  = state_q;
    assign heading     = heading_q;

endmodule

`default_nettype wire

// ==== logic/tick_gen.sv ====
`default_nettype none

`include "seg_game_defs.svh"

module tick_gen
    import seg_game_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    output ticks_t    ticks,
    output logic      blink_phase
);

    localparam int SAMPLE_W = $clog2(`SEG_SAMPLE_DIV);
    localparam int STEP_W   = $clog2(`SEG_STEP_DIV);
    localparam int BLINK_W  = $clog2(`SEG_BLINK_DIV);

    logic [SAMPLE_W-1:0] sample_cnt;
    logic [STEP_W-1:0]   step_cnt;
    logic [BLINK_W-1:0]  blink_cnt;

    logic sample_wrap;
    logic step_wrap;
    logic blink_wrap;

    assign sample_wrap = (sample_cnt == SAMPLE_W'(`SEG_SAMPLE_DIV - 1));
    assign step_wrap   = (step_cnt == STEP_W'(`SEG_STEP_DIV - 1));
    assign blink_wrap  = (blink_cnt == BLINK_W'(`SEG_BLINK_DIV - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sample_cnt  <= '0;
            step_cnt    <= '0;
            blink_cnt   <= '0;
            ticks       <= '0;
            blink_phase <= 1'b0;
        end else begin
            sample_cnt <= sample_wrap ? '0 : sample_cnt + 1'b1;
            step_cnt   <= step_wrap ? '0 : step_cnt + 1'b1;
            blink_cnt  <= blink_wrap ? '0 : blink_cnt + 1'b1;

            ticks.sample <= sample_wrap;
            ticks.step   <= step_wrap;
            ticks.blink  <= blink_wrap;

            // Phase flips on the cycle after its strobe
            if (ticks.blink) begin
                blink_phase <= ~blink_phase;
            end
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f vlog.f --top-module seg_game_tb \
    -Mdir "$build_dir" -o seg_game_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$build_dir/seg_game_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$log_file"; then
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$log_file"; then
    echo "No result line found in $log_file"
    exit 1
fi
exit 0

// ==== testbench/seg_game_tb.sv ====
`default_nettype none

`include "seg_game_defs.svh"

module seg_game_tb
    import seg_game_pkg::*;
;

    localparam int CLK_PERIOD = 20;
    localparam int N_WALK     = 6;
    localparam int STEP_LIMIT = 2 * (`SEG_START_STEPS + 1) + N_WALK + `SEG_FALL_STEPS + 11;

    logic        clk;
    logic        rst;
    buttons_t    btn;
    logic [6:0]  seg_n;
    logic [3:0]  digit_n;
    heading_e    heading;
    game_state_e state;

    // Reference model of the walker
    seg_id_e     m_seg;
    heading_e    m_heading;
    logic [6:0]  m_record;

    game_state_e prev_state;
    logic        prev_rst;
    logic        fall_entered;
    logic        fall_digit_on;
    logic        fall_digit_off;
    time         t_fall;
    logic [31:0] rnd_state;
    int          errors;
    int          tests_run;
    int          tests_passed;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    seg_game_top uut (
        .clk     (clk),
        .rst     (rst),
        .btn     (btn),
        .seg_n   (seg_n),
        .digit_n (digit_n),
        .heading (heading),
        .state   (state)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic buttons_t dir_to_buttons(input heading_e d);
        buttons_t b;
        b = '0;
        case (d)
            RIGHT: b.right = 1'b1;
            LEFT:  b.left  = 1'b1;
            UP:    b.up    = 1'b1;
            DOWN:  b.down  = 1'b1;
            default: b = '0;
        endcase
        return b;
    endfunction

    // Next segment and heading for a press along the heading
    function automatic logic [4:0] table_next(input seg_id_e s, input heading_e h);
        case ({s, h})
            {SEG_A, RIGHT}: return {SEG_B, DOWN};
            {SEG_B, DOWN}:  return {SEG_G, LEFT};
            {SEG_C, DOWN}:  return {SEG_D, LEFT};
            {SEG_D, LEFT}:  return {SEG_E, UP};
            {SEG_E, UP}:    return {SEG_G, RIGHT};
            {SEG_F, UP}:    return {SEG_A, RIGHT};
            {SEG_G, RIGHT}: return {SEG_C, DOWN};
            {SEG_G, LEFT}:  return {SEG_F, UP};
            default:        return {s, h};
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] t=%0t %s: expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_flag(input logic ok, input string what);
        assert (ok) else begin
            $display("Check failed at t=%0t: %s", $time, what);
            errors++;
        end
    endtask

    // Every segment except the current one against the model record
    task automatic check_segments();
        logic [6:0] mask;
        mask = ~(7'h1 << m_seg);
        check_value("seg_n", 32'(seg_n & mask), 32'(~m_record & mask));
    endtask

    task automatic press_button(input heading_e dir, input int hold_samples,
                                input int rest_samples);
        @(posedge clk);
        btn <= dir_to_buttons(dir);
        repeat (hold_samples * `SEG_SAMPLE_DIV) @(posedge clk);
        btn <= '0;
        repeat (rest_samples * `SEG_SAMPLE_DIV) @(posedge clk);
    endtask

    task automatic wait_for_state(input game_state_e target, input int max_cycles);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (state != target && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        check_flag(state == target, "timed out waiting for the expected game state");
    endtask

    task automatic reset_model();
        m_seg     = SEG_G;
        m_heading = LEFT;
        m_record  = '0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d check(s) failed", name, errors - errs_before);
        end
    endtask

    // Continuous checks on the display and the INITIAL phase
    always @(negedge clk) begin
        if (rst) begin
            check_value("digit_n", 32'(digit_n), 32'h0000000f);
            check_value("seg_n", 32'(seg_n), 32'h0000007f);
            check_value("state", 32'(state), 32'(INITIAL));
            check_value("heading", 32'(heading), 32'(LEFT));
        end else begin
            if (state == INITIAL) begin
                check_value("heading", 32'(heading), 32'(LEFT));
            end
            if (state == INITIAL && prev_state == INITIAL) begin
                check_value("seg_n[5:0]", 32'(seg_n[5:0]), 32'h0000003f);
            end
            if (!prev_rst && state != FALLING && prev_state != FALLING) begin
                check_value("digit_n", 32'(digit_n), 32'h0000000e);
            end
            if (state == FALLING) begin
                if (prev_state != FALLING) begin
                    fall_entered = 1'b1;
                    t_fall       = $time;
                end
                if (digit_n == 4'b1110) fall_digit_on = 1'b1;
                if (digit_n == 4'b1111) fall_digit_off = 1'b1;
            end
        end
        prev_state = state;
        prev_rst   = rst;
    end

    // Watchdog sized from the sum of the test lengths
    initial begin
        repeat (STEP_LIMIT * `SEG_STEP_DIV) @(posedge clk);
        $display("Watchdog expired after %0d step periods, the run did not finish", STEP_LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        time        t0;
        int         elapsed;
        int         errs;
        int         pick;
        logic [4:0] nxt;
        logic [6:0] first;
        logic [6:0] cur_mask;
        logic       seen_lit;
        logic       seen_dark;
        heading_e   wrong;

        btn            = '0;
        errors         = 0;
        tests_run      = 0;
        tests_passed   = 0;
        prev_state     = INITIAL;
        prev_rst       = 1'b1;
        fall_entered   = 1'b0;
        fall_digit_on  = 1'b0;
        fall_digit_off = 1'b0;
        t_fall         = 0;
        rnd_state      = 32'hbde4;
        reset_model();

        // State after reset and the first display update
        errs = errors;
        @(negedge rst);
        t0 = $time;
        @(negedge clk);
        check_value("state", 32'(state), 32'(INITIAL));
        check_value("heading", 32'(heading), 32'(LEFT));
        check_value("digit_n", 32'(digit_n), 32'h0000000f);
        report_test("reset", errs);

        // Presses in INITIAL are ignored and MOVING comes on time
        errs = errors;
        press_button(LEFT, 8, 8);
        wait_for_state(MOVING, (`SEG_START_STEPS + 1) * `SEG_STEP_DIV);
        elapsed = int'(($time - t0) / 64'(CLK_PERIOD));
        check_flag(elapsed >= `SEG_START_STEPS * `SEG_STEP_DIV &&
                   elapsed <= (`SEG_START_STEPS + 1) * `SEG_STEP_DIV,
                   "INITIAL phase length out of range");
        check_value("heading", 32'(heading), 32'(LEFT));
        check_segments();
        report_test("start", errs);

        // Walk the move table
        errs = errors;
        for (int i = 0; i < N_WALK; i++) begin
            nxt = table_next(m_seg, m_heading);
            press_button(m_heading, 8, 8);
            m_seg             = seg_id_e'(nxt[4:2]);
            m_heading         = heading_e'(nxt[1:0]);
            m_record[nxt[4:2]] = 1'b1;
            @(negedge clk);
            check_value("state", 32'(state), 32'(MOVING));
            check_value("heading", 32'(heading), 32'(m_heading));
            check_segments();
        end
        report_test("walk", errs);

        // Current segment blinks while the rest holds still
        errs = errors;
        cur_mask  = 7'h1 << m_seg;
        seen_lit  = 1'b0;
        seen_dark = 1'b0;
        @(negedge clk);
        first = seg_n;
        for (int i = 0; i < 4 * `SEG_BLINK_DIV; i++) begin
            check_value("seg_n", 32'(seg_n & ~cur_mask), 32'(first & ~cur_mask));
            if ((seg_n & cur_mask) == 7'h0) begin
                seen_lit = 1'b1;
            end else begin
                seen_dark = 1'b1;
            end
            @(negedge clk);
        end
        check_flag(seen_lit && seen_dark, "current segment did not blink during MOVING");
        report_test("blink", errs);

        // Wrong direction makes the walker fall
        errs = errors;
        rnd_state      = xorshift32(rnd_state);
        pick           = int'(rnd_state % 32'd3);
        wrong          = heading_e'(2'(int'(m_heading) + 1 + pick));
        fall_entered   = 1'b0;
        fall_digit_on  = 1'b0;
        fall_digit_off = 1'b0;
        press_button(wrong, 8, 0);
        wait_for_state(INITIAL, (`SEG_FALL_STEPS + 1) * `SEG_STEP_DIV);
        check_flag(fall_entered, "wrong direction did not enter FALLING");
        elapsed = int'(($time - t_fall) / 64'(CLK_PERIOD));
        check_flag(elapsed <= (`SEG_FALL_STEPS + 1) * `SEG_STEP_DIV,
                   "FALLING phase lasted too long");
        check_flag(fall_digit_on && fall_digit_off, "digit did not blink during FALLING");
        reset_model();
        @(negedge clk);
        check_value("heading", 32'(heading), 32'(LEFT));
        check_segments();
        report_test("fall", errs);

        // Short pulses are filtered out
        errs = errors;
        wait_for_state(MOVING, (`SEG_START_STEPS + 1) * `SEG_STEP_DIV);
        press_button(m_heading, 2, 8);
        @(negedge clk);
        check_value("heading", 32'(heading), 32'(m_heading));
        check_value("state", 32'(state), 32'(MOVING));
        rnd_state = xorshift32(rnd_state);
        pick      = int'(rnd_state % 32'd3);
        wrong     = heading_e'(2'(int'(m_heading) + 1 + pick));
        press_button(wrong, 2, 8);
        @(negedge clk);
        check_value("heading", 32'(heading), 32'(m_heading));
        check_value("state", 32'(state), 32'(MOVING));
        report_test("short pulse", errs);

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d failed checks",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held for the first 10 rising edges
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/seg_game_pkg.sv
logic/tick_gen.sv
logic/button_conditioner.sv
logic/segment_walker.sv
logic/segment_flasher.sv
logic/seg_game_top.sv
testbench/tb_clock.sv
testbench/seg_game_tb.sv
